// File: Makefile
TOP := mem_subsys_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module mem_subsys_top
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+dv
hw/mem_bus_pkg.sv
hw/cache_controller.sv
hw/icache.sv
hw/dcache.sv
hw/mem_model.sv
hw/mem_subsys_top.sv
dv/mem_subsys_tb.sv

// File: dv/mem_subsys_tb_tasks.svh
`ifndef mem_subsys_tb_tasks_svh
`define mem_subsys_tb_tasks_svh

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic [63:0] rand_word();
    logic [31:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
endfunction

// byte address to memory word, low 3 bits dropped
function automatic logic [mem_aw-1:0] word_of(input logic [31:0] addr);
    return mem_aw'(addr >> 3);
endfunction

// direct-mapped and read-only, so stores never reach a cached line
function automatic logic [63:0] icache_expect(input logic [31:0] addr);
    logic [icache_iw-1:0] line;
    logic [31:0]          tag;
    line = icache_iw'(addr >> 3);
    tag  = (addr >> 3) >> icache_iw;
    if (!iline_valid[line] || iline_tag[line] != tag) begin
        iline_valid[line] = 1'b1;
        iline_tag[line]   = tag;
        iline_data[line]  = ref_mem[word_of(addr)];
    end
    return iline_data[line];
endfunction

task automatic compare_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        $display("Simulation finished: FAIL");
        $fatal(1);
    end
endtask

// called 1 ns after a rising edge, returns at the same point
task automatic fetch_word(input logic [31:0] addr, output logic [63:0] data);
    proc2Icache_addr = addr;
    proc2Icache_req  = 1'b1;
    do begin
        @(posedge clock);
        #1;
    end while (!Icache2proc_valid);
    data            = Icache2proc_data;
    proc2Icache_req = 1'b0;
endtask

task automatic access_data(input bus_cmd_t cmd, input logic [31:0] addr,
                           input logic [63:0] wdata, output logic [63:0] rdata);
    proc2Dcache_command = cmd;
    proc2Dcache_addr    = addr;
    proc2Dcache_data    = wdata;
    do begin
        @(posedge clock);
        #1;
    end while (!Dcache2proc_valid);
    rdata               = Dcache2proc_data;
    proc2Dcache_command = bus_none;
    if (cmd == bus_store) begin
        ref_mem[word_of(addr)] = wdata;  // memory written at acceptance
    end
endtask

`endif

// File: dv/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;
    import mem_bus_pkg::*;

    localparam int n_directed = 13;
    localparam int n_window   = 12;  // words preloaded for the concurrent fetches
    localparam int n_fetch    = 24;  // window fetched twice
    localparam int n_data     = 48;
    localparam int n_rand     = 80;
    localparam int watchdog_cycles =
        (n_directed + n_window + n_fetch + n_data + n_rand) * (mem_latency + 10) * 2;

    localparam logic [63:0] word_a = 64'h0123_4567_89ab_cdef;
    localparam logic [63:0] word_b = 64'hfeed_face_cafe_beef;
    localparam logic [63:0] word_c = 64'h5a5a_0f0f_a5a5_f0f0;

    typedef struct {
        bit          on_d;  // data cache, else instruction cache
        bus_cmd_t    cmd;
        logic [31:0] addr;
        logic [63:0] data;
        logic [63:0] exp;
    } op_t;

    logic              clock;
    logic              rst_n;
    logic [xlen-1:0]   proc2Icache_addr;
    logic              proc2Icache_req;
    logic [data_w-1:0] Icache2proc_data;
    logic              Icache2proc_valid;
    bus_cmd_t          proc2Dcache_command;
    logic [xlen-1:0]   proc2Dcache_addr;
    logic [data_w-1:0] proc2Dcache_data;
    logic [data_w-1:0] Dcache2proc_data;
    logic              Dcache2proc_valid;

    logic [31:0] lcg_state = 32'he0e8_4d5c;
    bit   [63:0] ref_mem [mem_words];
    bit          iline_valid [icache_lines];
    logic [31:0] iline_tag [icache_lines];
    logic [63:0] iline_data [icache_lines];

    op_t ops [n_directed] = '{
        '{1'b1, bus_load,  32'h040, 64'd0,  64'd0},   // cold miss, zero memory
        '{1'b0, bus_load,  32'h080, 64'd0,  64'd0},
        '{1'b1, bus_load,  32'h040, 64'd0,  64'd0},   // now a hit
        '{1'b0, bus_load,  32'h080, 64'd0,  64'd0},
        '{1'b1, bus_store, 32'h100, word_a, 64'd0},
        '{1'b1, bus_load,  32'h100, 64'd0,  word_a},  // store did not allocate
        '{1'b0, bus_load,  32'h100, 64'd0,  word_a},
        '{1'b0, bus_load,  32'h100, 64'd0,  word_a},
        '{1'b1, bus_store, 32'h104, word_b, 64'd0},   // same word, hit line updated
        '{1'b1, bus_load,  32'h100, 64'd0,  word_b},
        '{1'b1, bus_store, 32'h180, word_c, 64'd0},   // also line 0
        '{1'b1, bus_load,  32'h180, 64'd0,  word_c},
        '{1'b1, bus_load,  32'h100, 64'd0,  word_b}
    };

    mem_subsys_top mem_subsys_top_i (.*);

    `include "mem_subsys_tb_tasks.svh"

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout: a cache request did not complete in %0d cycles", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    initial begin
        logic [63:0] got;
        logic [63:0] exp;
        logic [63:0] got_d;
        logic [63:0] exp_d;
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] daddr;

        rst_n               = 1'b0;
        proc2Icache_addr    = '0;
        proc2Icache_req     = 1'b0;
        proc2Dcache_command = bus_none;
        proc2Dcache_addr    = '0;
        proc2Dcache_data    = '0;
        repeat (10) @(posedge clock);
        #1 rst_n = 1'b1;
        compare_word("Icache2proc_valid", 64'(Icache2proc_valid), 64'd0);
        compare_word("Dcache2proc_valid", 64'(Dcache2proc_valid), 64'd0);

        foreach (ops[n]) begin
            if (!ops[n].on_d) begin
                void'(icache_expect(ops[n].addr));  // keep line model in step
                fetch_word(ops[n].addr, got);
                compare_word("Icache2proc_data", got, ops[n].exp);
            end else begin
                access_data(ops[n].cmd, ops[n].addr, ops[n].data, got);
                if (ops[n].cmd == bus_load) begin
                    compare_word("Dcache2proc_data", got, ops[n].exp);
                end
            end
        end

        for (int k = 0; k < n_window; k++) begin
            access_data(bus_store, 32'h400 + 32'(k * 8), rand_word(), got);
        end

        // fetch window and dcache region never overlap
        fork
            for (int k = 0; k < n_fetch; k++) begin
                addr = 32'h400 + 32'((k % n_window) * 8);
                exp  = icache_expect(addr);
                fetch_word(addr, got);
                compare_word("Icache2proc_data", got, exp);
            end
            for (int k = 0; k < n_data; k++) begin
                r     = lcg_next();
                daddr = 32'h600 + {24'd0, r[26:22], 3'b000};
                if (k % 4 == 3) begin
                    exp_d = ref_mem[word_of(daddr)];
                    access_data(bus_load, daddr, 64'd0, got_d);
                    compare_word("Dcache2proc_data", got_d, exp_d);
                end else begin
                    access_data(bus_store, daddr, rand_word(), got_d);
                end
            end
        join

        // whole array, low offset bits random too
        for (int k = 0; k < n_rand; k++) begin
            r    = lcg_next();
            addr = {21'd0, r[27:20], r[2:0]};
            case (r[31:30])
                2'd1: begin
                    exp = ref_mem[word_of(addr)];
                    access_data(bus_load, addr, 64'd0, got);
                    compare_word("Dcache2proc_data", got, exp);
                end
                2'd2: begin
                    exp = icache_expect(addr);
                    fetch_word(addr, got);
                    compare_word("Icache2proc_data", got, exp);
                end
                default: begin
                    access_data(bus_store, addr, rand_word(), got);
                end
            endcase
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: hw/cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
    // memory return
    input  logic [mem_bus_pkg::tag_w-1:0]  mem2proc_response, // zero unless accepted
    input  logic [mem_bus_pkg::data_w-1:0] mem2proc_data,
    input  logic [mem_bus_pkg::tag_w-1:0]  mem2proc_tag,

    // memory port
    output mem_bus_pkg::bus_cmd_t          proc2mem_command,
    output logic [mem_bus_pkg::xlen-1:0]   proc2mem_addr,
    output logic [mem_bus_pkg::data_w-1:0] proc2mem_data,

    // instruction cache side
    input  mem_bus_pkg::bus_cmd_t          Icache2ctrl_command,
    input  logic [mem_bus_pkg::xlen-1:0]   Icache2ctrl_addr,
    output logic [mem_bus_pkg::tag_w-1:0]  ctrl2Icache_response,
    output logic [mem_bus_pkg::data_w-1:0] ctrl2Icache_data,
    output logic [mem_bus_pkg::tag_w-1:0]  ctrl2Icache_tag,

    // data cache side
    input  mem_bus_pkg::bus_cmd_t          Dcache2ctrl_command,
    input  logic [mem_bus_pkg::xlen-1:0]   Dcache2ctrl_addr,
    input  logic [mem_bus_pkg::data_w-1:0] Dcache2ctrl_data,
    output logic [mem_bus_pkg::tag_w-1:0]  ctrl2Dcache_response,
    output logic [mem_bus_pkg::data_w-1:0] ctrl2Dcache_data,
    output logic [mem_bus_pkg::tag_w-1:0]  ctrl2Dcache_tag
);
    import mem_bus_pkg::*;

    logic d_request;

    assign d_request = (Dcache2ctrl_command != bus_none); // dcache always wins

    // the dcache issues nothing while it waits for its load, so it has to see
    // every return; its saved tag is unique among loads in flight
    assign ctrl2Dcache_data = mem2proc_data;
    assign ctrl2Dcache_tag  = mem2proc_tag;

    always_comb begin
        if (d_request) begin
            proc2mem_command     = Dcache2ctrl_command;
            proc2mem_addr        = Dcache2ctrl_addr;
            proc2mem_data        = Dcache2ctrl_data;
            ctrl2Dcache_response = mem2proc_response;
            ctrl2Icache_response = '0;  // icache retries later
            ctrl2Icache_data     = '0;
            ctrl2Icache_tag      = '0;
        end else begin
            proc2mem_command     = Icache2ctrl_command;
            proc2mem_addr        = Icache2ctrl_addr;
            proc2mem_data        = '0;  // icache never stores
            ctrl2Dcache_response = '0;
            ctrl2Icache_response = mem2proc_response;
            ctrl2Icache_data     = mem2proc_data;
            ctrl2Icache_tag      = mem2proc_tag;
        end
    end

endmodule

// File: hw/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                           clock,
    input  logic                           rst_n,

    // processor side, request held until valid
    input  mem_bus_pkg::bus_cmd_t          proc2Dcache_command,
    input  logic [mem_bus_pkg::xlen-1:0]   proc2Dcache_addr,
    input  logic [mem_bus_pkg::data_w-1:0] proc2Dcache_data,
    output logic [mem_bus_pkg::data_w-1:0] Dcache2proc_data,
    output logic                           Dcache2proc_valid,

    // controller side
    output mem_bus_pkg::bus_cmd_t          Dcache2ctrl_command,
    output logic [mem_bus_pkg::xlen-1:0]   Dcache2ctrl_addr,
    output logic [mem_bus_pkg::data_w-1:0] Dcache2ctrl_data,
    input  logic [mem_bus_pkg::tag_w-1:0]  ctrl2Dcache_response,
    input  logic [mem_bus_pkg::data_w-1:0] ctrl2Dcache_data,
    input  logic [mem_bus_pkg::tag_w-1:0]  ctrl2Dcache_tag
);
    import mem_bus_pkg::*;

    logic [dcache_tw-1:0]    tag_mem  [dcache_lines];
    logic [data_w-1:0]       data_mem [dcache_lines];
    logic [dcache_lines-1:0] valid_mem;

    cache_state_t         state;
    logic [tag_w-1:0]     wait_tag;
    logic [data_w-1:0]    out_data;
    logic [dcache_iw-1:0] idx;
    logic [dcache_tw-1:0] addr_tag;
    logic                 hit;
    logic                 is_store;
    logic                 accepted;
    logic                 fill;

    assign idx      = proc2Dcache_addr[byte_off_w +: dcache_iw];
    assign addr_tag = proc2Dcache_addr[xlen-1 -: dcache_tw];
    assign hit      = valid_mem[idx] && (tag_mem[idx] == addr_tag);
    assign is_store = (proc2Dcache_command == bus_store);
    assign accepted = (state == cache_issue) && (ctrl2Dcache_response != '0);
    assign fill     = (state == cache_wait) && (ctrl2Dcache_tag == wait_tag);

    // command held until accepted, none while waiting
    assign Dcache2ctrl_command = (state == cache_issue) ? proc2Dcache_command : bus_none;
    assign Dcache2ctrl_addr    = {proc2Dcache_addr[xlen-1:byte_off_w], {byte_off_w{1'b0}}};
    assign Dcache2ctrl_data    = (state == cache_issue && is_store) ? proc2Dcache_data : '0;
    assign Dcache2proc_valid   = (state == cache_done);
    assign Dcache2proc_data    = out_data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cache_idle;
            wait_tag  <= '0;
            valid_mem <= '0;
        end else begin
            case (state)
                cache_idle: begin
                    if (proc2Dcache_command == bus_load && hit) begin
                        state <= cache_done;
                    end else if (proc2Dcache_command != bus_none) begin
                        state <= cache_issue;  // load miss or any store
                    end
                end
                cache_issue: begin
                    if (accepted) begin
                        wait_tag <= ctrl2Dcache_response;
                        state    <= is_store ? cache_done : cache_wait;
                    end
                end
                cache_wait: begin
                    if (fill) begin
                        valid_mem[idx] <= 1'b1;
                        state          <= cache_done;
                    end
                end
                default: begin
                    state <= cache_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == cache_idle && proc2Dcache_command == bus_load && hit) begin
            out_data <= data_mem[idx];
        end
        if (accepted && is_store) begin
            out_data <= proc2Dcache_data;
            if (hit) begin
                data_mem[idx] <= proc2Dcache_data; // write-through, no allocate
            end
        end
        if (fill) begin
            tag_mem[idx]  <= addr_tag;
            data_mem[idx] <= ctrl2Dcache_data;
            out_data      <= ctrl2Dcache_data;
        end
    end

endmodule

// File: hw/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                           clock,
    input  logic                           rst_n,

    // processor side, request held until valid
    input  logic [mem_bus_pkg::xlen-1:0]   proc2Icache_addr,
    input  logic                           proc2Icache_req,
    output logic [mem_bus_pkg::data_w-1:0] Icache2proc_data,
    output logic                           Icache2proc_valid,

    // controller side
    output mem_bus_pkg::bus_cmd_t          Icache2ctrl_command,
    output logic [mem_bus_pkg::xlen-1:0]   Icache2ctrl_addr,
    input  logic [mem_bus_pkg::tag_w-1:0]  ctrl2Icache_response,
    input  logic [mem_bus_pkg::data_w-1:0] ctrl2Icache_data,
    input  logic [mem_bus_pkg::tag_w-1:0]  ctrl2Icache_tag
);
    import mem_bus_pkg::*;

    // line storage
    logic [icache_tw-1:0]    tag_mem  [icache_lines];
    logic [data_w-1:0]       data_mem [icache_lines];
    logic [icache_lines-1:0] valid_mem;

    cache_state_t         state;
    logic [tag_w-1:0]     wait_tag;   // response tag of the outstanding miss
    logic [data_w-1:0]    out_data;
    logic [icache_iw-1:0] idx;
    logic [icache_tw-1:0] addr_tag;
    logic                 hit;
    logic                 accepted;
    logic                 fill;

    assign idx      = proc2Icache_addr[byte_off_w +: icache_iw];
    assign addr_tag = proc2Icache_addr[xlen-1 -: icache_tw];
    assign hit      = valid_mem[idx] && (tag_mem[idx] == addr_tag);
    assign accepted = (state == cache_issue) && (ctrl2Icache_response != '0);
    assign fill     = (state == cache_wait) && (ctrl2Icache_tag == wait_tag);

    assign Icache2ctrl_command = (state == cache_issue) ? bus_load : bus_none;
    assign Icache2ctrl_addr    = {proc2Icache_addr[xlen-1:byte_off_w], {byte_off_w{1'b0}}};
    assign Icache2proc_valid   = (state == cache_done);
    assign Icache2proc_data    = out_data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cache_idle;
            wait_tag  <= '0;
            valid_mem <= '0;
        end else begin
            case (state)
                cache_idle: begin
                    if (proc2Icache_req) begin
                        state <= hit ? cache_done : cache_issue;
                    end
                end
                cache_issue: begin
                    if (accepted) begin   // otherwise retry next cycle
                        wait_tag <= ctrl2Icache_response;
                        state    <= cache_wait;
                    end
                end
                cache_wait: begin
                    if (fill) begin
                        valid_mem[idx] <= 1'b1;
                        state          <= cache_done;
                    end
                end
                default: begin
                    state <= cache_idle;  // one cycle of valid
                end
            endcase
        end
    end

    // line and answer payload
    always_ff @(posedge clock) begin
        if (state == cache_idle && proc2Icache_req && hit) begin
            out_data <= data_mem[idx];
        end
        if (fill) begin
            tag_mem[idx]  <= addr_tag;
            data_mem[idx] <= ctrl2Icache_data;
            out_data      <= ctrl2Icache_data;
        end
    end

endmodule

// File: hw/mem_bus_pkg.sv
package mem_bus_pkg;

    // bus widths
    localparam int xlen   = 32;
    localparam int data_w = 64;
    localparam int tag_w  = 4;

    // addresses are byte addresses of 8-byte words
    localparam int byte_off_w = 3;

    // memory model
    localparam int mem_latency = 8;   // accept to data return
    localparam int mem_words   = 256;
    localparam int mem_aw      = $clog2(mem_words);

    // cache geometry, both direct-mapped with one word per line
    localparam int icache_lines = 16;
    localparam int icache_iw    = $clog2(icache_lines);
    localparam int icache_tw    = xlen - byte_off_w - icache_iw;
    localparam int dcache_lines = 16;
    localparam int dcache_iw    = $clog2(dcache_lines);
    localparam int dcache_tw    = xlen - byte_off_w - dcache_iw;

    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_cmd_t;

    // shared by both cache FSMs
    typedef enum logic [1:0] {
        cache_idle,
        cache_issue,   // command on the bus until a nonzero response
        cache_wait,    // load accepted, watching for the saved tag
        cache_done     // answer to the processor
    } cache_state_t;

endpackage

// File: hw/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                           clock,
    input  logic                           rst_n,

    input  mem_bus_pkg::bus_cmd_t          proc2mem_command,
    input  logic [mem_bus_pkg::xlen-1:0]   proc2mem_addr,
    input  logic [mem_bus_pkg::data_w-1:0] proc2mem_data,

    output logic [mem_bus_pkg::tag_w-1:0]  mem2proc_response,
    output logic [mem_bus_pkg::data_w-1:0] mem2proc_data,
    output logic [mem_bus_pkg::tag_w-1:0]  mem2proc_tag
);
    import mem_bus_pkg::*;

    logic [data_w-1:0] mem [mem_words];

    // return pipeline, tag 0 marks an empty slot
    logic [tag_w-1:0]  pipe_tag  [mem_latency];
    logic [data_w-1:0] pipe_data [mem_latency];
    logic [tag_w-1:0]  hold_tag;   // last stage delayed one cycle
    logic [data_w-1:0] hold_data;

    logic [tag_w-1:0]  tag_cnt;
    logic [mem_aw-1:0] word_idx;
    logic              accept;
    logic              is_load;
    logic              last_live;

    assign accept    = (proc2mem_command != bus_none);
    assign is_load   = (proc2mem_command == bus_load);
    assign word_idx  = proc2mem_addr[byte_off_w +: mem_aw];
    assign last_live = (pipe_tag[mem_latency-1] != '0);

    assign mem2proc_response = accept ? tag_cnt : '0;

    // a fresh return wins over the held one
    assign mem2proc_tag  = last_live ? pipe_tag[mem_latency-1] : hold_tag;
    assign mem2proc_data = last_live ? pipe_data[mem_latency-1] : hold_data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (proc2mem_command == bus_store) begin
            mem[word_idx] <= proc2mem_data;  // written at acceptance
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tag_cnt  <= tag_w'(1);
            hold_tag <= '0;
            for (int i = 0; i < mem_latency; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            if (accept) begin
                // 1..15 then back to 1
                tag_cnt <= (tag_cnt == '1) ? tag_w'(1) : tag_cnt + tag_w'(1);
            end
            pipe_tag[0] <= is_load ? tag_cnt : '0; // stores return nothing
            for (int i = 1; i < mem_latency; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
            hold_tag <= pipe_tag[mem_latency-1];
        end
    end

    // read at acceptance, data rides along with its tag
    always_ff @(posedge clock) begin
        pipe_data[0] <= mem[word_idx];
        for (int i = 1; i < mem_latency; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
        hold_data <= pipe_data[mem_latency-1];
    end

endmodule

// File: hw/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                           clock,
    input  logic                           rst_n,

    input  logic [mem_bus_pkg::xlen-1:0]   proc2Icache_addr,
    input  logic                           proc2Icache_req,
    output logic [mem_bus_pkg::data_w-1:0] Icache2proc_data,
    output logic                           Icache2proc_valid,

    input  mem_bus_pkg::bus_cmd_t          proc2Dcache_command,
    input  logic [mem_bus_pkg::xlen-1:0]   proc2Dcache_addr,
    input  logic [mem_bus_pkg::data_w-1:0] proc2Dcache_data,
    output logic [mem_bus_pkg::data_w-1:0] Dcache2proc_data,
    output logic                           Dcache2proc_valid
);
    import mem_bus_pkg::*;

    // caches to controller
    bus_cmd_t          Icache2ctrl_command;
    logic [xlen-1:0]   Icache2ctrl_addr;
    logic [tag_w-1:0]  ctrl2Icache_response;
    logic [data_w-1:0] ctrl2Icache_data;
    logic [tag_w-1:0]  ctrl2Icache_tag;
    bus_cmd_t          Dcache2ctrl_command;
    logic [xlen-1:0]   Dcache2ctrl_addr;
    logic [data_w-1:0] Dcache2ctrl_data;
    logic [tag_w-1:0]  ctrl2Dcache_response;
    logic [data_w-1:0] ctrl2Dcache_data;
    logic [tag_w-1:0]  ctrl2Dcache_tag;

    // controller to memory
    bus_cmd_t          proc2mem_command;
    logic [xlen-1:0]   proc2mem_addr;
    logic [data_w-1:0] proc2mem_data;
    logic [tag_w-1:0]  mem2proc_response;
    logic [data_w-1:0] mem2proc_data;
    logic [tag_w-1:0]  mem2proc_tag;

    icache icache_i (.*);

    dcache dcache_i (.*);

    cache_controller cache_controller_i (.*);

    mem_model mem_model_i (.*);

endmodule
